/* hdl/video_pkg.sv */
package video_pkg;

    // pixel data
    typedef logic [7:0] channel_t;       // one 8 bit color channel

    // raster positions, sized for 1280x720 plus blanking
    typedef logic [10:0] hcount_t;       // horizontal position
    typedef logic [9:0]  vcount_t;       // vertical position

    // per-frame tally
    typedef logic [31:0] sum_t;          // sum of x or y over one frame
    typedef logic [20:0] count_t;        // masked pixel count, 1280*720 fits

    // channel selector, code 3 picks nothing and the mask stays low
    typedef logic [1:0] channel_sel_t;

    localparam channel_sel_t SEL_GREEN = 2'd0;
    localparam channel_sel_t SEL_RED   = 2'd1;
    localparam channel_sel_t SEL_BLUE  = 2'd2;

    // crosshair pixels are written full white
    localparam channel_t CROSS_LEVEL = '1;

endpackage

/* hdl/tally_if.sv */
`timescale 1ns/1ps

// one frame's tally, passed over a four-phase req/ack handshake
interface tally_if;
    import video_pkg::*;

    logic   req;     // producer has a stable tally
    logic   ack;     // consumer has latched it
    sum_t   x_sum;   // sum of masked x coordinates
    sum_t   y_sum;   // sum of masked y coordinates
    count_t count;   // number of masked pixels

    modport producer (
        output req, x_sum, y_sum, count,
        input  ack
    );

    modport consumer (
        input  req, x_sum, y_sum, count,
        output ack
    );

endinterface

/* hdl/video_timing.sv */
`timescale 1ns/1ps

module video_timing #(
    parameter int H_ACTIVE = 1280,
    parameter int H_FRONT  = 110,
    parameter int H_SYNC   = 40,
    parameter int H_BACK   = 220,
    parameter int V_ACTIVE = 720,
    parameter int V_FRONT  = 5,
    parameter int V_SYNC   = 5,
    parameter int V_BACK   = 20
) (
    input  logic               clk_pixel,
    input  logic               recent_reset,
    output video_pkg::hcount_t hcount,
    output video_pkg::vcount_t vcount,
    output logic               hsync,
    output logic               vsync,
    output logic               active_draw,
    output logic               new_frame
);
    import video_pkg::*;

    localparam int H_TOTAL  = H_ACTIVE + H_FRONT + H_SYNC + H_BACK;
    localparam int V_TOTAL  = V_ACTIVE + V_FRONT + V_SYNC + V_BACK;
    localparam int HS_START = H_ACTIVE + H_FRONT;    // first hsync column
    localparam int VS_START = V_ACTIVE + V_FRONT;    // first vsync line

    hcount_t h_next;   // position for the next cycle
    vcount_t v_next;
    logic    line_end; // last column of a line

    // next raster position, flags below are decoded from it so they line up
    // with the registered counters
    always_comb begin
        line_end = (hcount == hcount_t'(H_TOTAL - 1));
        h_next   = line_end ? '0 : hcount + 1'b1;
        v_next   = vcount;
        if (line_end) begin
            v_next = (vcount == vcount_t'(V_TOTAL - 1)) ? '0 : vcount + 1'b1;
        end
    end

    always_ff @(posedge clk_pixel) begin
        if (recent_reset) begin
            hcount      <= '0;
            vcount      <= '0;
            hsync       <= 1'b0;
            vsync       <= 1'b0;
            active_draw <= 1'b0;
            new_frame   <= 1'b0;
        end else begin
            hcount      <= h_next;
            vcount      <= v_next;
            active_draw <= (h_next < hcount_t'(H_ACTIVE)) && (v_next < vcount_t'(V_ACTIVE));
            hsync       <= (h_next >= hcount_t'(HS_START))
                        && (h_next < hcount_t'(HS_START + H_SYNC));  // active high
            vsync       <= (v_next >= vcount_t'(VS_START))
                        && (v_next < vcount_t'(VS_START + V_SYNC));
            // one column past the last active pixel of the last active line
            new_frame   <= (h_next == hcount_t'(H_ACTIVE)) && (v_next == vcount_t'(V_ACTIVE - 1));
        end
    end

    // frame marker is a single cycle wide
    a_new_frame_pulse : assert property (@(posedge clk_pixel) disable iff (recent_reset)
        new_frame |=> !new_frame)
        else $error("new_frame held for two cycles");

endmodule

/* hdl/mask_tally.sv */
`timescale 1ns/1ps

module mask_tally (
    input  logic                    clk_pixel,
    input  logic                    recent_reset,
    input  video_pkg::channel_sel_t channel_sel,
    input  video_pkg::channel_t     lower_bound,
    input  video_pkg::channel_t     upper_bound,
    input  video_pkg::channel_t     red_in,
    input  video_pkg::channel_t     green_in,
    input  video_pkg::channel_t     blue_in,
    input  video_pkg::hcount_t      hcount,
    input  video_pkg::vcount_t      vcount,
    input  logic                    active_draw,
    input  logic                    new_frame,
    tally_if.producer               tally
);
    import video_pkg::*;

    typedef enum logic [1:0] {S_IDLE, S_REQUESTING, S_RELEASING} hs_state_t;

    hs_state_t state;
    channel_t  chan;         // selected channel value
    logic      chan_ok;      // selector points at a real channel
    logic      in_range;
    logic      mask_d;       // registered mask bit
    hcount_t   x_d;          // coordinates aligned with mask_d
    vcount_t   y_d;
    logic      new_frame_d;  // frame end, one cycle late so the last pixel lands
    sum_t      x_acc;        // running sums for the current frame
    sum_t      y_acc;
    count_t    n_acc;

    always_comb begin
        chan_ok = 1'b1;
        case (channel_sel)
            SEL_GREEN: chan = green_in;
            SEL_RED:   chan = red_in;
            SEL_BLUE:  chan = blue_in;
            default: begin
                chan    = '0;
                chan_ok = 1'b0;    // no channel, nothing passes
            end
        endcase
        in_range = chan_ok && (chan >= lower_bound) && (chan <= upper_bound);  // inclusive
    end

    always_ff @(posedge clk_pixel) begin
        x_d <= hcount;
        y_d <= vcount;
        if (recent_reset) begin
            mask_d      <= 1'b0;
            new_frame_d <= 1'b0;
            x_acc       <= '0;
            y_acc       <= '0;
            n_acc       <= '0;
            state       <= S_IDLE;
            tally.req   <= 1'b0;
        end else begin
            mask_d      <= in_range && active_draw;
            new_frame_d <= new_frame;
            if (new_frame_d) begin
                // sums restart every frame, sent or not
                x_acc <= '0;
                y_acc <= '0;
                n_acc <= '0;
            end else if (mask_d) begin
                x_acc <= x_acc + sum_t'(x_d);
                y_acc <= y_acc + sum_t'(y_d);
                n_acc <= n_acc + 1'b1;
            end
            case (state)
                S_IDLE: if (new_frame_d && !tally.ack) begin
                    tally.x_sum <= x_acc;   // only loaded with req and ack low
                    tally.y_sum <= y_acc;
                    tally.count <= n_acc;
                    tally.req   <= 1'b1;
                    state       <= S_REQUESTING;
                end
                S_REQUESTING: if (tally.ack) begin
                    tally.req <= 1'b0;
                    state     <= S_RELEASING;
                end
                S_RELEASING: if (!tally.ack) state <= S_IDLE;  // frames ending here are dropped
                default: state <= S_IDLE;
            endcase
        end
    end

    // req only drops after the consumer answered
    a_req_held : assert property (@(posedge clk_pixel) disable iff (recent_reset)
        $fell(tally.req) |-> $past(tally.ack))
        else $error("req fell without ack");

endmodule

/* hdl/com_divider.sv */
`timescale 1ns/1ps

module com_divider (
    input  logic               clk_pixel,
    input  logic               recent_reset,
    tally_if.consumer          tally,
    output logic               com_valid,
    output video_pkg::hcount_t x_com,
    output video_pkg::vcount_t y_com
);
    import video_pkg::*;

    localparam int QBITS = $bits(sum_t);       // quotient bits per division
    localparam int RBITS = $bits(count_t) + 1; // remainder plus the shifted-in bit
    localparam int CNT_W = $clog2(QBITS);

    typedef enum logic [1:0] {S_IDLE, S_DIV_X, S_DIV_Y, S_DONE} div_state_t;

    div_state_t       state;
    logic             take;      // accept a tally this cycle
    sum_t             quo;       // dividend shifting out, quotient shifting in
    count_t           rem;       // partial remainder, always below the divisor
    count_t           divisor;
    sum_t             y_data;    // y sum waits here while x is divided
    hcount_t          x_res;
    logic [CNT_W-1:0] bit_cnt;   // quotient bits left, minus one
    logic [RBITS-1:0] shifted;
    logic             fits;
    logic [RBITS-1:0] rem_next;
    sum_t             quo_next;

    assign take = tally.req && !tally.ack && (state == S_IDLE);

    // one restoring step, shared by the x and y passes
    always_comb begin
        shifted  = {rem, quo[QBITS-1]};
        fits     = (shifted >= {1'b0, divisor});
        rem_next = fits ? shifted - {1'b0, divisor} : shifted;
        quo_next = {quo[QBITS-2:0], fits};
    end

    // ack side, may drop while the division is still busy
    always_ff @(posedge clk_pixel) begin
        if (recent_reset) tally.ack <= 1'b0;
        else if (take) tally.ack <= 1'b1;
        else if (tally.ack && !tally.req) tally.ack <= 1'b0;
    end

    always_ff @(posedge clk_pixel) begin
        if (take) begin
            quo     <= tally.x_sum;   // x first
            y_data  <= tally.y_sum;
            divisor <= tally.count;
        end else if (state == S_DIV_X && bit_cnt == '0) begin
            quo <= y_data;
        end else if (state == S_DIV_X || state == S_DIV_Y) begin
            quo <= quo_next;
        end
        rem     <= (take || state == S_DIV_X && bit_cnt == '0) ? '0 : count_t'(rem_next);
        bit_cnt <= (state == S_DIV_X || state == S_DIV_Y) ? bit_cnt - 1'b1 : CNT_W'(QBITS - 1);
        if (state == S_DIV_X && bit_cnt == '0) x_res <= hcount_t'(quo_next);  // mean < H_ACTIVE
        if (recent_reset) begin
            state     <= S_IDLE;
            com_valid <= 1'b0;
            x_com     <= '0;
            y_com     <= '0;
        end else begin
            com_valid <= 1'b0;
            case (state)
                S_IDLE:  if (take && tally.count != '0) state <= S_DIV_X;  // empty frame ignored
                S_DIV_X: if (bit_cnt == '0) state <= S_DIV_Y;
                S_DIV_Y: if (bit_cnt == '0) state <= S_DONE;
                S_DONE: begin
                    com_valid <= 1'b1;
                    x_com     <= x_res;
                    y_com     <= vcount_t'(quo);
                    state     <= S_IDLE;
                end
                default: state <= S_IDLE;
            endcase
        end
    end

    a_ack_on_req : assert property (@(posedge clk_pixel) disable iff (recent_reset)
        $rose(tally.ack) |-> tally.req)
        else $error("ack rose without req");

    a_nonzero_div : assert property (@(posedge clk_pixel) disable iff (recent_reset)
        (state == S_IDLE) ##1 (state == S_DIV_X) |-> (divisor != '0))
        else $error("division started with zero divisor");

endmodule

/* hdl/crosshair_overlay.sv */
`timescale 1ns/1ps

module crosshair_overlay (
    input  logic                clk_pixel,
    input  logic                recent_reset,
    input  logic                com_valid,
    input  video_pkg::hcount_t  x_com,
    input  video_pkg::vcount_t  y_com,
    input  video_pkg::hcount_t  hcount,
    input  video_pkg::vcount_t  vcount,
    input  logic                hsync,
    input  logic                vsync,
    input  logic                active_draw,
    input  video_pkg::channel_t red_in,
    input  video_pkg::channel_t green_in,
    input  video_pkg::channel_t blue_in,
    output video_pkg::channel_t red_out,
    output video_pkg::channel_t green_out,
    output video_pkg::channel_t blue_out,
    output logic                hsync_out,
    output logic                vsync_out,
    output logic                active_out
);
    import video_pkg::*;

    hcount_t x_held;    // latest center of mass
    vcount_t y_held;
    hcount_t x_now;     // new value counts in its own cycle
    vcount_t y_now;
    logic    on_cross;

    always_comb begin
        x_now    = com_valid ? x_com : x_held;
        y_now    = com_valid ? y_com : y_held;
        on_cross = (hcount == x_now) || (vcount == y_now);  // column or row hit
    end

    always_ff @(posedge clk_pixel) begin
        red_out   <= on_cross ? CROSS_LEVEL : red_in;
        green_out <= on_cross ? CROSS_LEVEL : green_in;
        blue_out  <= on_cross ? CROSS_LEVEL : blue_in;
        if (recent_reset) begin
            x_held     <= '0;
            y_held     <= '0;
            hsync_out  <= 1'b0;
            vsync_out  <= 1'b0;
            active_out <= 1'b0;
        end else begin
            x_held     <= x_now;
            y_held     <= y_now;
            hsync_out  <= hsync;   // syncs ride along with the pixel
            vsync_out  <= vsync;
            active_out <= active_draw;
        end
    end

endmodule

/* hdl/com_tracker_top.sv */
`timescale 1ns/1ps

module com_tracker_top #(
    parameter int H_ACTIVE = 1280,
    parameter int H_FRONT  = 110,
    parameter int H_SYNC   = 40,
    parameter int H_BACK   = 220,
    parameter int V_ACTIVE = 720,
    parameter int V_FRONT  = 5,
    parameter int V_SYNC   = 5,
    parameter int V_BACK   = 20
) (
    input  logic                    clk_pixel,
    input  logic                    recent_reset,
    input  video_pkg::channel_sel_t channel_sel,
    input  video_pkg::channel_t     lower_bound,
    input  video_pkg::channel_t     upper_bound,
    input  video_pkg::channel_t     red_in,
    input  video_pkg::channel_t     green_in,
    input  video_pkg::channel_t     blue_in,
    output video_pkg::hcount_t      hcount,
    output video_pkg::vcount_t      vcount,
    output logic                    hsync,
    output logic                    vsync,
    output logic                    active_draw,
    output logic                    new_frame,
    output video_pkg::channel_t     red_out,
    output video_pkg::channel_t     green_out,
    output video_pkg::channel_t     blue_out,
    output logic                    hsync_out,
    output logic                    vsync_out,
    output logic                    active_out,
    output logic                    com_valid,
    output video_pkg::hcount_t      x_com,
    output video_pkg::vcount_t      y_com
);

    tally_if tally ();   // frame tally, mask_tally to com_divider

    video_timing #(
        .H_ACTIVE(H_ACTIVE), .H_FRONT(H_FRONT), .H_SYNC(H_SYNC), .H_BACK(H_BACK),
        .V_ACTIVE(V_ACTIVE), .V_FRONT(V_FRONT), .V_SYNC(V_SYNC), .V_BACK(V_BACK)
    ) timing (
        .clk_pixel(clk_pixel), .recent_reset(recent_reset),
        .hcount(hcount), .vcount(vcount), .hsync(hsync), .vsync(vsync),
        .active_draw(active_draw), .new_frame(new_frame)
    );

    mask_tally tally_gen (
        .clk_pixel(clk_pixel), .recent_reset(recent_reset),
        .channel_sel(channel_sel), .lower_bound(lower_bound), .upper_bound(upper_bound),
        .red_in(red_in), .green_in(green_in), .blue_in(blue_in),
        .hcount(hcount), .vcount(vcount), .active_draw(active_draw), .new_frame(new_frame),
        .tally(tally.producer)
    );

    com_divider divider (
        .clk_pixel(clk_pixel), .recent_reset(recent_reset), .tally(tally.consumer),
        .com_valid(com_valid), .x_com(x_com), .y_com(y_com)
    );

    crosshair_overlay overlay (
        .clk_pixel(clk_pixel), .recent_reset(recent_reset),
        .com_valid(com_valid), .x_com(x_com), .y_com(y_com),
        .hcount(hcount), .vcount(vcount), .hsync(hsync), .vsync(vsync),
        .active_draw(active_draw),
        .red_in(red_in), .green_in(green_in), .blue_in(blue_in),
        .red_out(red_out), .green_out(green_out), .blue_out(blue_out),
        .hsync_out(hsync_out), .vsync_out(vsync_out), .active_out(active_out)
    );

endmodule

/* bench/tb_com_tracker.sv */
`timescale 1ns/1ps

module tb_com_tracker;
    import video_pkg::*;

    // small raster, 24 x 12 = 288 cycles per frame
    localparam int H_ACTIVE = 16, H_FRONT = 2, H_SYNC = 2, H_BACK = 4;
    localparam int V_ACTIVE = 8,  V_FRONT = 1, V_SYNC = 1, V_BACK = 2;
    localparam int H_TOTAL = H_ACTIVE + H_FRONT + H_SYNC + H_BACK;
    localparam int V_TOTAL = V_ACTIVE + V_FRONT + V_SYNC + V_BACK;
    localparam int FRAME_CYCLES = H_TOTAL * V_TOTAL;
    localparam int N_TESTS = 6;
    localparam longint WATCHDOG_NS = longint'(N_TESTS * 6 * FRAME_CYCLES + 200) * 8;
    localparam channel_t LOWER = 8'd100;   // mask bounds, inclusive
    localparam channel_t UPPER = 8'd200;
    localparam int SCENE_BLANK = 0;        // noise only
    localparam int SCENE_RECT  = 1;        // red block
    localparam int SCENE_EDGES = 2;        // bound values in red, a blue block

    logic         clk_pixel, recent_reset;
    channel_sel_t channel_sel;
    channel_t     lower_bound, upper_bound, red_in, green_in, blue_in;
    hcount_t      hcount, x_com;
    vcount_t      vcount, y_com;
    logic         hsync, vsync, active_draw, new_frame, com_valid;
    channel_t     red_out, green_out, blue_out;
    logic         hsync_out, vsync_out, active_out;

    integer       seed;                    // noise source
    int           error_count, test_count, failed_tests, closes;
    int           scene, next_scene;
    channel_sel_t next_sel;
    longint       x_acc, y_acc, n_acc;     // expected tally of the frame being drawn
    logic         armed;                   // first frame after reset is partial
    logic         pending;                 // a com_valid is owed
    hcount_t      exp_x, last_x;
    vcount_t      exp_y, last_y;
    logic         released;                // reset was low at the last edge
    logic         settled;                 // two edges past reset release
    hcount_t      exp_h;                   // raster position model
    vcount_t      exp_v;
    logic         exp_active, exp_hsync, exp_vsync, exp_new_frame;
    logic         prev_cross;
    logic [23:0]  prev_pix;                // {r, g, b} of the previous cycle
    logic [2:0]   prev_syncs;

    com_tracker_top #(
        .H_ACTIVE(H_ACTIVE), .H_FRONT(H_FRONT), .H_SYNC(H_SYNC), .H_BACK(H_BACK),
        .V_ACTIVE(V_ACTIVE), .V_FRONT(V_FRONT), .V_SYNC(V_SYNC), .V_BACK(V_BACK)
    ) dut (.*);

    initial begin
        clk_pixel = 1'b0;
        forever #4 clk_pixel = ~clk_pixel;   // 8 ns period
    end

    initial begin
        #(WATCHDOG_NS);
        $display("TIMEOUT: the run did not finish within %0d ns", WATCHDOG_NS);
        $display("Test failures found");
        $finish;
    end

    // raster regions straight from the parameters
    assign exp_active = (hcount < hcount_t'(H_ACTIVE)) && (vcount < vcount_t'(V_ACTIVE));
    assign exp_hsync  = (hcount >= hcount_t'(H_ACTIVE + H_FRONT))
                     && (hcount < hcount_t'(H_ACTIVE + H_FRONT + H_SYNC));
    assign exp_vsync  = (vcount >= vcount_t'(V_ACTIVE + V_FRONT))
                     && (vcount < vcount_t'(V_ACTIVE + V_FRONT + V_SYNC));
    assign exp_new_frame = (hcount == hcount_t'(H_ACTIVE)) && (vcount == vcount_t'(V_ACTIVE - 1));

    always @(posedge clk_pixel) begin
        released   <= !recent_reset;
        settled    <= released;
        prev_cross <= (hcount == x_com) || (vcount == y_com);  // crosshair row or column
        prev_pix   <= {red_in, green_in, blue_in};
        prev_syncs <= {hsync, vsync, active_draw};
    end

    // counters advance every cycle and wrap at the line and frame totals
    always @(posedge clk_pixel) begin
        if (recent_reset) begin
            exp_h <= '0;
            exp_v <= '0;
        end else if (exp_h == hcount_t'(H_TOTAL - 1)) begin
            exp_h <= '0;
            exp_v <= (exp_v == vcount_t'(V_TOTAL - 1)) ? '0 : exp_v + 1'b1;
        end else begin
            exp_h <= exp_h + 1'b1;
        end
    end

    task automatic report_mismatch(input string name, input logic [31:0] got,
                                   input logic [31:0] expected);
        error_count++;
        $display("CHECK FAILED %s: got %h, expected %h", name, got, expected);
    endtask

    task automatic report_problem(input string what);
        error_count++;
        $display("ERROR: %s", what);
    endtask

    // outputs settle to their reset values one edge into reset
    a_reset_flags : assert property (@(posedge clk_pixel)
        recent_reset |=> ({hsync_out, vsync_out, active_out, com_valid} == 4'h0))
        else report_mismatch("{hsync_out,vsync_out,active_out,com_valid}",
                             $sampled({hsync_out, vsync_out, active_out, com_valid}), 0);
    a_reset_x : assert property (@(posedge clk_pixel) recent_reset |=> (x_com == '0))
        else report_mismatch("x_com", $sampled(x_com), 0);
    a_reset_y : assert property (@(posedge clk_pixel) recent_reset |=> (y_com == '0))
        else report_mismatch("y_com", $sampled(y_com), 0);

    a_position : assert property (@(posedge clk_pixel) disable iff (recent_reset || !settled)
        {hcount, vcount} == {exp_h, exp_v})
        else report_mismatch("{hcount,vcount}", $sampled({hcount, vcount}),
                             $sampled({exp_h, exp_v}));
    a_active : assert property (@(posedge clk_pixel) disable iff (recent_reset || !settled)
        active_draw == exp_active)
        else report_mismatch("active_draw", $sampled(active_draw), $sampled(exp_active));
    a_hsync : assert property (@(posedge clk_pixel) disable iff (recent_reset || !settled)
        hsync == exp_hsync)
        else report_mismatch("hsync", $sampled(hsync), $sampled(exp_hsync));
    a_vsync : assert property (@(posedge clk_pixel) disable iff (recent_reset || !settled)
        vsync == exp_vsync)
        else report_mismatch("vsync", $sampled(vsync), $sampled(exp_vsync));
    a_new_frame : assert property (@(posedge clk_pixel) disable iff (recent_reset || !settled)
        new_frame == exp_new_frame)  // one pulse per frame, at its position
        else report_mismatch("new_frame", $sampled(new_frame), $sampled(exp_new_frame));

    // overlay output is the previous cycle's pixel or the crosshair
    a_red_out : assert property (@(posedge clk_pixel) disable iff (recent_reset || !settled)
        red_out == (prev_cross ? CROSS_LEVEL : prev_pix[23:16]))
        else report_mismatch("red_out", $sampled(red_out),
                             $sampled(prev_cross ? CROSS_LEVEL : prev_pix[23:16]));
    a_green_out : assert property (@(posedge clk_pixel) disable iff (recent_reset || !settled)
        green_out == (prev_cross ? CROSS_LEVEL : prev_pix[15:8]))
        else report_mismatch("green_out", $sampled(green_out),
                             $sampled(prev_cross ? CROSS_LEVEL : prev_pix[15:8]));
    a_blue_out : assert property (@(posedge clk_pixel) disable iff (recent_reset || !settled)
        blue_out == (prev_cross ? CROSS_LEVEL : prev_pix[7:0]))
        else report_mismatch("blue_out", $sampled(blue_out),
                             $sampled(prev_cross ? CROSS_LEVEL : prev_pix[7:0]));
    a_sync_out : assert property (@(posedge clk_pixel) disable iff (recent_reset || !settled)
        {hsync_out, vsync_out, active_out} == prev_syncs)
        else report_mismatch("{hsync_out,vsync_out,active_out}",
                             $sampled({hsync_out, vsync_out, active_out}), $sampled(prev_syncs));

    // random channel value that never lands inside the bounds
    function automatic channel_t noise_value();
        int r;
        r = int'($unsigned($random(seed)) % 155);
        return (r < 100) ? channel_t'(r) : channel_t'(r + 101);  // 0..99 or 201..255
    endfunction

    function automatic logic [23:0] scene_pixel(input int sc, input int h, input int v,
                                                input logic [23:0] noise);
        logic [23:0] pix;
        pix = noise;
        case (sc)
            SCENE_RECT: if (h >= 3 && h <= 8 && v >= 2 && v <= 5) pix[23:16] = 8'd150;
            SCENE_EDGES: begin
                if (h == 0 && v == 0)  pix[23:16] = LOWER - 8'd1;  // just outside
                if (h == 1 && v == 0)  pix[23:16] = UPPER + 8'd1;
                if (h == 2 && v == 1)  pix[23:16] = 8'd150;
                if (h == 14 && v == 6) pix[23:16] = LOWER;         // exactly on the bounds
                if (h == 13 && v == 7) pix[23:16] = UPPER;
                if (h >= 10 && h <= 13 && v >= 4 && v <= 6) pix[7:0] = 8'd120;
            end
            default: ;
        endcase
        return pix;
    endfunction

    function automatic logic masked(input logic [23:0] pix, input channel_sel_t sel);
        channel_t c;
        case (sel)
            SEL_GREEN: c = pix[15:8];
            SEL_RED:   c = pix[23:16];
            SEL_BLUE:  c = pix[7:0];
            default:   return 1'b0;   // selector 3 masks nothing
        endcase
        return (c >= LOWER) && (c <= UPPER);
    endfunction

    task automatic check_com();
        if (com_valid) begin
            if (!pending) begin
                report_problem("com_valid pulsed with no frame result owed");
            end else begin
                assert (x_com == exp_x) else report_mismatch("x_com", x_com, exp_x);
                assert (y_com == exp_y) else report_mismatch("y_com", y_com, exp_y);
            end
            pending = 1'b0;
            last_x  = x_com;
            last_y  = y_com;
        end else begin
            // between pulses the result holds
            assert (x_com == last_x) else report_mismatch("x_com", x_com, last_x);
            assert (y_com == last_y) else report_mismatch("y_com", y_com, last_y);
        end
    endtask

    // frame end, the previous result must be in by now
    task automatic close_frame();
        assert (!pending) else report_problem("com_valid missing for the previous frame");
        pending = 1'b0;
        if (armed && n_acc != 0) begin
            pending = 1'b1;
            exp_x   = hcount_t'(x_acc / n_acc);   // floored mean
            exp_y   = vcount_t'(y_acc / n_acc);
        end
        armed = 1'b1;
        x_acc = 0;
        y_acc = 0;
        n_acc = 0;
        closes++;
        scene       = next_scene;   // close cycle is in blanking, safe to switch
        channel_sel = next_sel;
    endtask

    task automatic drive_cycle();
        int          h;
        int          v;
        logic [23:0] pix;
        @(posedge clk_pixel);
        #1;
        h = int'(hcount);
        v = int'(vcount);
        check_com();
        if (h == H_ACTIVE && v == V_ACTIVE - 1) close_frame();
        pix = scene_pixel(scene, h, v, {noise_value(), noise_value(), noise_value()});
        {red_in, green_in, blue_in} = pix;
        if (armed && h < H_ACTIVE && v < V_ACTIVE && masked(pix, channel_sel)) begin
            x_acc += h;
            y_acc += v;
            n_acc++;
        end
    endtask

    // n frames of a scene, then a blank frame so the last result gets checked
    task automatic run_frames(input int sc, input channel_sel_t sel, input int n);
        int c0;
        c0         = closes;
        next_scene = sc;
        next_sel   = sel;
        while (closes < c0 + n + 2) begin
            drive_cycle();
            if (closes >= c0 + n) begin
                next_scene = SCENE_BLANK;
                next_sel   = SEL_RED;
            end
        end
    endtask

    task automatic finish_test(input string name, input int errs_before);
        test_count++;
        if (error_count == errs_before) begin
            $display("PASS: %s", name);
        end else begin
            failed_tests++;
            $display("FAIL: %s (%0d failed checks)", name, error_count - errs_before);
        end
    endtask

    initial begin
        int errs;
        seed         = 30110;
        error_count  = 0;
        test_count   = 0;
        failed_tests = 0;
        closes       = 0;
        scene        = SCENE_BLANK;
        next_scene   = SCENE_BLANK;
        next_sel     = SEL_RED;
        armed        = 1'b0;
        pending      = 1'b0;
        x_acc        = 0;
        y_acc        = 0;
        n_acc        = 0;
        exp_x        = '0;
        exp_y        = '0;
        last_x       = '0;
        last_y       = '0;
        recent_reset = 1'b1;
        channel_sel  = SEL_RED;
        lower_bound  = LOWER;
        upper_bound  = UPPER;
        red_in       = '0;
        green_in     = '0;
        blue_in      = '0;

        errs = error_count;
        repeat (16) @(posedge clk_pixel);
        #1 recent_reset = 1'b0;
        repeat (2) drive_cycle();   // reset values seen right after release
        finish_test("reset", errs);

        errs = error_count;
        run_frames(SCENE_BLANK, SEL_RED, 2);
        finish_test("raster", errs);

        errs = error_count;
        run_frames(SCENE_RECT, SEL_RED, 2);
        finish_test("center of mass", errs);

        errs = error_count;
        run_frames(SCENE_EDGES, SEL_RED, 1);
        run_frames(SCENE_EDGES, SEL_BLUE, 1);   // blue block moves the result
        finish_test("bounds and channel select", errs);

        errs = error_count;
        run_frames(SCENE_BLANK, SEL_RED, 1);
        run_frames(SCENE_RECT, channel_sel_t'(3), 1);
        finish_test("empty frame", errs);

        errs = error_count;
        run_frames(SCENE_RECT, SEL_RED, 1);
        run_frames(SCENE_EDGES, SEL_RED, 1);    // crosshair jumps between the two
        finish_test("overlay", errs);

        $display("tests run: %0d, tests failed: %0d, failed checks: %0d",
                 test_count, failed_tests, error_count);
        if (error_count == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

/* list.f */
hdl/video_pkg.sv
hdl/tally_if.sv
hdl/video_timing.sv
hdl/mask_tally.sv
hdl/com_divider.sv
hdl/crosshair_overlay.sv
hdl/com_tracker_top.sv
bench/tb_com_tracker.sv

/* run.sh */
#!/usr/bin/env bash
# build and run the tracker testbench with Verilator
set -u
cd "$(dirname "$0")" || exit 1

LOG=sim.log
TOP=tb_com_tracker

verilator --binary --timing --assert -Wno-fatal -f list.f --top-module "$TOP" -o "$TOP"
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/"$TOP" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

# the log decides the verdict
if grep -q "Test failures found" "$LOG"; then
    echo "simulation reported failures"
    exit 1
fi
echo "simulation clean"
exit 0
